// ==== design/cache_pkg.sv ====
package cache_pkg;

   //////////////////////////////////////////////////////////////////////
   // Widths
   //////////////////////////////////////////////////////////////////////
   localparam int addr_w     = 16;                     // Byte address of cache space
   localparam int data_w     = 32;
   localparam int nbytes     = data_w / 8;             // Strobe and wb_sel width
   localparam int byte_w     = 2;                      // Byte offset bits
   localparam int index_w    = 4;                      // 16 lines
   localparam int tag_w      = addr_w - index_w - byte_w;
   localparam int nlines     = 1 << index_w;
   localparam int wadr_w     = addr_w - byte_w;        // Wishbone word address
   localparam int cnt_w      = 16;                     // Hit/miss counters
   localparam int ctrl_sel_w = 2;

   // Control register selects, one word apart
   localparam logic [ctrl_sel_w-1:0] ctrl_hits       = 2'd0;
   localparam logic [ctrl_sel_w-1:0] ctrl_misses     = 2'd1;
   localparam logic [ctrl_sel_w-1:0] ctrl_invalidate = 2'd2;
   localparam logic [ctrl_sel_w-1:0] ctrl_clear      = 2'd3;

   // FSM state encoding
   localparam int          state_w   = 2;
   localparam logic [1:0]  st_idle   = 2'd0;
   localparam logic [1:0]  st_lookup = 2'd1;        // Tag compare
   localparam logic [1:0]  st_bus    = 2'd2;        // Wishbone access in flight
   localparam logic [1:0]  st_done   = 2'd3;        // Answer after ack

   // Front address word, seen as cache address or as control select
   typedef union packed {
      struct packed {
         logic [tag_w-1:0]   tag;
         logic [index_w-1:0] index;
         logic [byte_w-1:0]  offset;
      } mem;
      struct packed {
         logic [addr_w-ctrl_sel_w-byte_w-1:0] rsvd;   // Ignored
         logic [ctrl_sel_w-1:0]               sel;
         logic [byte_w-1:0]                   offset;
      } ctrl;
   } cache_addr_u;

endpackage

// ==== design/cache_front_end.sv ====
module cache_front_end
   (
   input  logic                               clk,
   input  logic                               reset,
   // Front port, MSB of addr selects control space
   input  logic [cache_pkg::addr_w:0]         addr,
   input  logic [cache_pkg::data_w-1:0]       wdata,
   input  logic [cache_pkg::nbytes-1:0]       wstrb,
   input  logic                               valid,
   output logic                               ready,
   output logic [cache_pkg::data_w-1:0]       rdata,
   // Cache memory side
   output logic                               req_valid,
   output cache_pkg::cache_addr_u             req_addr,
   output logic [cache_pkg::data_w-1:0]       req_wdata,
   output logic [cache_pkg::nbytes-1:0]       req_wstrb,
   input  logic                               data_ready,
   input  logic [cache_pkg::data_w-1:0]       data_rdata,
   // Cache control side
   output logic                               ctrl_valid,
   output logic [cache_pkg::ctrl_sel_w-1:0]   ctrl_sel,
   output logic                               ctrl_write,
   input  logic                               ctrl_ready,
   input  logic [cache_pkg::data_w-1:0]       ctrl_rdata
   );

   logic busy;        // One request in flight
   logic accept;
   logic sel_ctrl;    // Select bit of incoming address

   assign sel_ctrl = addr[cache_pkg::addr_w];
   assign accept   = valid & ~busy;

   //////////////////////////////////////////////////////////////////////
   // Handshake and steering
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         busy       <= 1'b0;
         req_valid  <= 1'b0;
         ctrl_valid <= 1'b0;
      end
      else
      begin
         req_valid  <= accept & ~sel_ctrl;    // Single-cycle pulses
         ctrl_valid <= accept & sel_ctrl;
         if (accept)
            busy <= 1'b1;
         else if (ready)
            busy <= 1'b0;                     // Either side answered
      end
   end

   // Registered copy of the request, held until the next acceptance
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         req_addr  <= addr[cache_pkg::addr_w-1:0];
         req_wdata <= wdata;
         req_wstrb <= wstrb;
      end
   end

   // Same register decoded as control select
   assign ctrl_sel   = req_addr.ctrl.sel;
   assign ctrl_write = |req_wstrb;            // Any strobe means write

   // Merge answers, at most one ready per cycle
   assign ready = data_ready | ctrl_ready;
   assign rdata = ctrl_ready ? ctrl_rdata : data_rdata;

endmodule

// ==== design/cache_fsm.sv ====
module cache_fsm
   (
   input  logic                               clk,
   input  logic                               reset,
   // Request from front end
   input  logic                               req_valid,
   input  cache_pkg::cache_addr_u             req_addr,
   input  logic [cache_pkg::data_w-1:0]       req_wdata,
   input  logic [cache_pkg::nbytes-1:0]       req_wstrb,
   output logic                               data_ready,
   output logic [cache_pkg::data_w-1:0]       data_rdata,
   // Store access
   output logic [cache_pkg::index_w-1:0]      rd_index,
   output logic                               wr_en,
   output logic [cache_pkg::index_w-1:0]      wr_index,
   output logic [cache_pkg::tag_w-1:0]        wr_tag,
   output logic [cache_pkg::nbytes-1:0]       wr_strb,
   output logic [cache_pkg::data_w-1:0]       wr_data,
   output logic                               set_valid,
   input  logic [cache_pkg::tag_w-1:0]        rd_tag,
   input  logic                               rd_valid,
   input  logic [cache_pkg::data_w-1:0]       rd_data,
   // Counter events
   output logic                               hit,
   output logic                               miss,
   // Wishbone classic master
   output logic                               wb_cyc,
   output logic                               wb_stb,
   output logic                               wb_we,
   output logic [cache_pkg::wadr_w-1:0]       wb_adr,
   output logic [cache_pkg::data_w-1:0]       wb_dat_o,
   output logic [cache_pkg::nbytes-1:0]       wb_sel,
   input  logic [cache_pkg::data_w-1:0]       wb_dat_i,
   input  logic                               wb_ack
   );

   logic [cache_pkg::state_w-1:0] state;
   logic [cache_pkg::data_w-1:0]  fill_q;     // Word returned by memory
   logic                          is_write;
   logic                          tag_match;
   logic                          in_lookup;
   logic                          in_done;

   assign is_write  = |req_wstrb;
   assign tag_match = rd_valid && (rd_tag == req_addr.mem.tag);
   assign in_lookup = (state == cache_pkg::st_lookup);
   assign in_done   = (state == cache_pkg::st_done);

   //////////////////////////////////////////////////////////////////////
   // State register
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         state <= cache_pkg::st_idle;
      else
      begin
         case (state)
            cache_pkg::st_idle:
               if (req_valid)
                  state <= cache_pkg::st_lookup;
            cache_pkg::st_lookup:
               if (!is_write && tag_match)
                  state <= cache_pkg::st_idle;    // Read hit answered here
               else
                  state <= cache_pkg::st_bus;     // Refill or write-through
            cache_pkg::st_bus:
               if (wb_ack)
                  state <= cache_pkg::st_done;    // Wait out slave stalls
            default:
               state <= cache_pkg::st_idle;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (wb_cyc && wb_ack)
         fill_q <= wb_dat_i;
   end

   // Lookup results
   assign hit  = in_lookup & tag_match;
   assign miss = in_lookup & ~tag_match;

   assign data_ready = (in_lookup & tag_match & ~is_write) | in_done;
   assign data_rdata = in_done ? fill_q : rd_data;

   //////////////////////////////////////////////////////////////////////
   // Store control
   //////////////////////////////////////////////////////////////////////
   assign rd_index  = req_addr.mem.index;      // Read issued while idle
   assign wr_index  = req_addr.mem.index;
   assign wr_tag    = req_addr.mem.tag;
   assign set_valid = in_done & ~is_write;     // Line fill after refill
   assign wr_en     = (in_lookup & tag_match & is_write) | set_valid;
   assign wr_strb   = set_valid ? {cache_pkg::nbytes{1'b1}} : req_wstrb;
   assign wr_data   = set_valid ? fill_q : req_wdata;

   // Single access, fields stable from the held request
   assign wb_cyc   = (state == cache_pkg::st_bus);
   assign wb_stb   = wb_cyc;
   assign wb_we    = is_write;
   assign wb_adr   = req_addr[cache_pkg::addr_w-1:cache_pkg::byte_w];
   assign wb_dat_o = req_wdata;
   assign wb_sel   = is_write ? req_wstrb : {cache_pkg::nbytes{1'b1}};

endmodule

// ==== design/cache_store.sv ====
module cache_store
   (
   input  logic                               clk,
   input  logic                               reset,
   input  logic [cache_pkg::index_w-1:0]      rd_index,
   input  logic                               wr_en,
   input  logic [cache_pkg::index_w-1:0]      wr_index,
   input  logic [cache_pkg::tag_w-1:0]        wr_tag,
   input  logic [cache_pkg::nbytes-1:0]       wr_strb,
   input  logic [cache_pkg::data_w-1:0]       wr_data,
   input  logic                               set_valid,
   input  logic                               inv_all,
   output logic [cache_pkg::tag_w-1:0]        rd_tag,
   output logic                               rd_valid,
   output logic [cache_pkg::data_w-1:0]       rd_data
   );

   logic [cache_pkg::tag_w-1:0]  tag_mem  [cache_pkg::nlines];
   logic [cache_pkg::data_w-1:0] data_mem [cache_pkg::nlines];
   logic [cache_pkg::nlines-1:0] valid_q;    // One bit per line

   //////////////////////////////////////////////////////////////////////
   // Valid bits
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         valid_q  <= '0;
         rd_valid <= 1'b0;
      end
      else
      begin
         rd_valid <= valid_q[rd_index];
         if (inv_all)
            valid_q <= '0;                     // Invalidate wins
         else if (wr_en && set_valid)
            valid_q[wr_index] <= 1'b1;
      end
   end

   // Tag and data arrays
   always_ff @(posedge clk)
   begin
      rd_tag  <= tag_mem[rd_index];            // Synchronous read
      rd_data <= data_mem[rd_index];
      if (wr_en)
         tag_mem[wr_index] <= wr_tag;
      for (int b = 0; b < cache_pkg::nbytes; b++)
      begin
         if (wr_en && wr_strb[b])
            data_mem[wr_index][b*8 +: 8] <= wr_data[b*8 +: 8];
      end
   end

endmodule

// ==== design/cache_ctrl.sv ====
module cache_ctrl
   (
   input  logic                               clk,
   input  logic                               reset,
   input  logic                               ctrl_valid,
   input  logic [cache_pkg::ctrl_sel_w-1:0]   ctrl_sel,
   input  logic                               ctrl_write,
   input  logic                               hit,
   input  logic                               miss,
   output logic                               ctrl_ready,
   output logic [cache_pkg::data_w-1:0]       ctrl_rdata,
   output logic                               inv_all
   );

   logic [cache_pkg::cnt_w-1:0] hits_q;
   logic [cache_pkg::cnt_w-1:0] misses_q;
   logic                        do_clear;

   assign do_clear = ctrl_valid & ctrl_write & (ctrl_sel == cache_pkg::ctrl_clear);

   //////////////////////////////////////////////////////////////////////
   // Saturating counters and command pulses
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         hits_q     <= '0;
         misses_q   <= '0;
         ctrl_ready <= 1'b0;
         inv_all    <= 1'b0;
      end
      else
      begin
         ctrl_ready <= ctrl_valid;             // Answer one cycle later
         inv_all    <= ctrl_valid & ctrl_write & (ctrl_sel == cache_pkg::ctrl_invalidate);
         if (do_clear)
         begin
            hits_q   <= '0;
            misses_q <= '0;
         end
         else
         begin
            if (hit && hits_q != '1)
               hits_q <= hits_q + 1'b1;        // Stick at max
            if (miss && misses_q != '1)
               misses_q <= misses_q + 1'b1;
         end
      end
   end

   // Read data, zero extended; writes answer zero
   always_ff @(posedge clk)
   begin
      ctrl_rdata <= '0;
      if (ctrl_valid && !ctrl_write && ctrl_sel == cache_pkg::ctrl_hits)
         ctrl_rdata <= {{(cache_pkg::data_w-cache_pkg::cnt_w){1'b0}}, hits_q};
      else if (ctrl_valid && !ctrl_write && ctrl_sel == cache_pkg::ctrl_misses)
         ctrl_rdata <= {{(cache_pkg::data_w-cache_pkg::cnt_w){1'b0}}, misses_q};
   end

endmodule

// ==== design/cache_top.sv ====
module cache_top
   (
   input  logic                               clk,
   input  logic                               reset,
   // Front port
   input  logic [cache_pkg::addr_w:0]         addr,
   input  logic [cache_pkg::data_w-1:0]       wdata,
   input  logic [cache_pkg::nbytes-1:0]       wstrb,
   input  logic                               valid,
   output logic                               ready,
   output logic [cache_pkg::data_w-1:0]       rdata,
   // Wishbone master to memory
   output logic                               wb_cyc,
   output logic                               wb_stb,
   output logic                               wb_we,
   output logic [cache_pkg::wadr_w-1:0]       wb_adr,
   output logic [cache_pkg::data_w-1:0]       wb_dat_o,
   output logic [cache_pkg::nbytes-1:0]       wb_sel,
   input  logic [cache_pkg::data_w-1:0]       wb_dat_i,
   input  logic                               wb_ack
   );

   // Front end to FSM
   logic                             req_valid;
   cache_pkg::cache_addr_u           req_addr;
   logic [cache_pkg::data_w-1:0]     req_wdata;
   logic [cache_pkg::nbytes-1:0]     req_wstrb;
   logic                             data_ready;
   logic [cache_pkg::data_w-1:0]     data_rdata;
   // Front end to control
   logic                             ctrl_valid;
   logic [cache_pkg::ctrl_sel_w-1:0] ctrl_sel;
   logic                             ctrl_write;
   logic                             ctrl_ready;
   logic [cache_pkg::data_w-1:0]     ctrl_rdata;
   // FSM to store
   logic [cache_pkg::index_w-1:0]    rd_index;
   logic                             wr_en;
   logic [cache_pkg::index_w-1:0]    wr_index;
   logic [cache_pkg::tag_w-1:0]      wr_tag;
   logic [cache_pkg::nbytes-1:0]     wr_strb;
   logic [cache_pkg::data_w-1:0]     wr_data;
   logic                             set_valid;
   logic [cache_pkg::tag_w-1:0]      rd_tag;
   logic                             rd_valid;
   logic [cache_pkg::data_w-1:0]     rd_data;
   // Events and commands
   logic                             hit;
   logic                             miss;
   logic                             inv_all;

   //////////////////////////////////////////////////////////////////////
   // Blocks
   //////////////////////////////////////////////////////////////////////
   cache_front_end i_cache_front_end
      (
      .clk        (clk),
      .reset      (reset),
      .addr       (addr),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .valid      (valid),
      .ready      (ready),
      .rdata      (rdata),
      .req_valid  (req_valid),
      .req_addr   (req_addr),
      .req_wdata  (req_wdata),
      .req_wstrb  (req_wstrb),
      .data_ready (data_ready),
      .data_rdata (data_rdata),
      .ctrl_valid (ctrl_valid),
      .ctrl_sel   (ctrl_sel),
      .ctrl_write (ctrl_write),
      .ctrl_ready (ctrl_ready),
      .ctrl_rdata (ctrl_rdata)
      );

   cache_fsm i_cache_fsm
      (
      .clk        (clk),
      .reset      (reset),
      .req_valid  (req_valid),
      .req_addr   (req_addr),
      .req_wdata  (req_wdata),
      .req_wstrb  (req_wstrb),
      .data_ready (data_ready),
      .data_rdata (data_rdata),
      .rd_index   (rd_index),
      .wr_en      (wr_en),
      .wr_index   (wr_index),
      .wr_tag     (wr_tag),
      .wr_strb    (wr_strb),
      .wr_data    (wr_data),
      .set_valid  (set_valid),
      .rd_tag     (rd_tag),
      .rd_valid   (rd_valid),
      .rd_data    (rd_data),
      .hit        (hit),
      .miss       (miss),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_o   (wb_dat_o),
      .wb_sel     (wb_sel),
      .wb_dat_i   (wb_dat_i),
      .wb_ack     (wb_ack)
      );

   cache_store i_cache_store
      (
      .clk        (clk),
      .reset      (reset),
      .rd_index   (rd_index),
      .wr_en      (wr_en),
      .wr_index   (wr_index),
      .wr_tag     (wr_tag),
      .wr_strb    (wr_strb),
      .wr_data    (wr_data),
      .set_valid  (set_valid),
      .inv_all    (inv_all),
      .rd_tag     (rd_tag),
      .rd_valid   (rd_valid),
      .rd_data    (rd_data)
      );

   cache_ctrl i_cache_ctrl
      (
      .clk        (clk),
      .reset      (reset),
      .ctrl_valid (ctrl_valid),
      .ctrl_sel   (ctrl_sel),
      .ctrl_write (ctrl_write),
      .hit        (hit),
      .miss       (miss),
      .ctrl_ready (ctrl_ready),
      .ctrl_rdata (ctrl_rdata),
      .inv_all    (inv_all)
      );

endmodule

// ==== sim/cache_assert.sv ====
module cache_assert
   (
   input logic                           clk,
   input logic                           reset,
   input logic                           ready,
   input logic                           wb_cyc,
   input logic                           wb_stb,
   input logic                           wb_ack,
   input logic [cache_pkg::wadr_w-1:0]   wb_adr
   );
   timeunit 1ns;
   timeprecision 100ps;

   int fail_count = 0;    // Read by the testbench at the end

   //////////////////////////////////////////////////////////////////////
   // Wishbone classic master rules
   //////////////////////////////////////////////////////////////////////
   stb_in_cycle: assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc)
      else
      begin
         fail_count++;
         $error("wb_stb high outside a bus cycle");
      end

   // Cycle held with a fixed address until the slave acks
   cyc_until_ack: assert property (@(posedge clk) disable iff (reset)
      wb_cyc && !wb_ack |=> wb_cyc && $stable(wb_adr))
      else
      begin
         fail_count++;
         $error("bus cycle dropped or address moved before ack");
      end

   // Front port answers with single-cycle pulses
   ready_pulse: assert property (@(posedge clk) disable iff (reset) ready |=> !ready)
      else
      begin
         fail_count++;
         $error("ready high for two cycles in a row");
      end

endmodule

bind cache_top cache_assert i_cache_assert
   (
   .clk    (clk),
   .reset  (reset),
   .ready  (ready),
   .wb_cyc (wb_cyc),
   .wb_stb (wb_stb),
   .wb_ack (wb_ack),
   .wb_adr (wb_adr)
   );

// ==== sim/cache_tb.sv ====
module cache_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int mem_words  = 4096;     // 16 KB main memory
   localparam int wait_limit = 200;      // Cycles before a wait gives up

   logic                           clk;
   logic                           reset;
   logic [cache_pkg::addr_w:0]     addr;
   logic [cache_pkg::data_w-1:0]   wdata;
   logic [cache_pkg::nbytes-1:0]   wstrb;
   logic                           valid;
   logic                           ready;
   logic [cache_pkg::data_w-1:0]   rdata;
   logic                           wb_cyc;
   logic                           wb_stb;
   logic                           wb_we;
   logic [cache_pkg::wadr_w-1:0]   wb_adr;
   logic [cache_pkg::data_w-1:0]   wb_dat_o;
   logic [cache_pkg::nbytes-1:0]   wb_sel;
   logic [cache_pkg::data_w-1:0]   wb_dat_i;
   logic                           wb_ack;

   logic [31:0]                  mem     [mem_words];   // Slave contents
   logic [31:0]                  exp_mem [mem_words];   // Reference copy
   logic [cache_pkg::tag_w-1:0]  exp_tag [16];
   logic [15:0]                  exp_valid;
   int                           exp_hits;
   int                           exp_misses;
   int                           bus_reads;             // Completed Wishbone reads
   int                           bus_writes;
   int                           errors;
   int                           tests_run;
   int                           tests_failed;
   integer                       seed = 32'hb828;

   cache_top i_cache_top
      (
      .clk      (clk),
      .reset    (reset),
      .addr     (addr),
      .wdata    (wdata),
      .wstrb    (wstrb),
      .valid    (valid),
      .ready    (ready),
      .rdata    (rdata),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_o (wb_dat_o),
      .wb_sel   (wb_sel),
      .wb_dat_i (wb_dat_i),
      .wb_ack   (wb_ack)
      );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;    // 20 ns period
   end

   // Memory fill, every address bit shows up in the word
   function automatic logic [31:0] fill_word(int w);
      return {4'ha, w[11:0], 4'h5, ~w[11:0]};
   endfunction

   function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] d,
                                               logic [3:0] s);
      logic [31:0] res;
      res = old;
      for (int b = 0; b < 4; b++)
      begin
         if (s[b])
            res[b*8 +: 8] = d[b*8 +: 8];    // Strobed lanes only
      end
      return res;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Wishbone slave, 0 to 3 wait states per access
   //////////////////////////////////////////////////////////////////////
   initial
   begin : wb_slave
      int          stall;
      logic [11:0] w;
      wb_ack     = 1'b0;
      wb_dat_i   = '0;
      bus_reads  = 0;
      bus_writes = 0;
      for (int i = 0; i < mem_words; i++)
         mem[i] = fill_word(i);
      forever
      begin
         @(negedge clk);
         if (wb_cyc && wb_stb)
         begin
            stall = $random(seed) & 3;
            repeat (stall) @(negedge clk);
            w = wb_adr[11:0];               // 16 KB wraps
            @(posedge clk);
            wb_ack <= 1'b1;
            if (wb_we)
            begin
               mem[w] = merge_bytes(mem[w], wb_dat_o, wb_sel);
               bus_writes++;
            end
            else
            begin
               if (wb_sel !== 4'hf)
                  report_value("wb_sel", 32'hf, 32'(wb_sel));   // Refill takes whole word
               wb_dat_i <= mem[w];
               bus_reads++;
            end
            @(posedge clk);
            wb_ack <= 1'b0;                 // One-cycle ack
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Reporting and reference model
   //////////////////////////////////////////////////////////////////////
   task automatic report_value(string name, logic [31:0] expected, logic [31:0] actual);
      errors++;
      $display("error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
   endtask

   task automatic stop_run(string why);
      $display("%s at %0d ns", why, $time);
      $display("TB FAILED");
      $finish;
   endtask

   task automatic finish_test(string name, int err0);
      tests_run++;
      if (errors > err0)
      begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - err0);
      end
      else
         $display("test %s: ok", name);
   endtask

   task automatic model_init();
      exp_valid  = '0;
      exp_hits   = 0;
      exp_misses = 0;
      for (int i = 0; i < mem_words; i++)
         exp_mem[i] = fill_word(i);
   endtask

   // Control reads, counters zero extended
   function automatic logic [31:0] ctrl_expect(logic [1:0] sel);
      if (sel == cache_pkg::ctrl_hits)
         return exp_hits;
      else if (sel == cache_pkg::ctrl_misses)
         return exp_misses;
      return '0;
   endfunction

   // One front-port transfer, lat is cycles from valid sampled to ready
   task automatic front_access(input logic [16:0] a, input logic [31:0] d,
                               input logic [3:0] s, output logic [31:0] data,
                               output int lat);
      int waited;
      waited = 0;
      @(posedge clk);
      addr  <= a;
      wdata <= d;
      wstrb <= s;
      valid <= 1'b1;
      @(negedge clk);
      while (ready !== 1'b1)
      begin
         waited++;
         if (waited > wait_limit)
            stop_run("cache never raised ready");
         @(negedge clk);
      end
      data = rdata;
      lat  = waited;
      @(posedge clk);
      valid <= 1'b0;                         // Dropped with the ready edge
      wstrb <= '0;
   endtask

   task automatic rd(input logic [16:0] a, output logic [31:0] data, output int nrd,
                     output int lat);
      logic [3:0]                  idx;
      logic [cache_pkg::tag_w-1:0] tg;
      logic                        hit_exp;
      logic [31:0]                 data_exp;
      int                          nrd_exp;
      int                          rd0;
      idx      = a[5:2];
      tg       = a[15:6];
      hit_exp  = exp_valid[idx] && (exp_tag[idx] == tg);
      data_exp = a[16] ? ctrl_expect(a[3:2]) : exp_mem[a[13:2]];
      nrd_exp  = (a[16] || hit_exp) ? 0 : 1;
      rd0      = bus_reads;
      front_access(a, '0, '0, data, lat);
      nrd = bus_reads - rd0;
      if (data !== data_exp)
         report_value("rdata", data_exp, data);
      if (nrd != nrd_exp)
         report_value("Wishbone reads", nrd_exp, nrd);
      if (!a[16] && hit_exp)
         exp_hits++;
      else if (!a[16])
      begin
         exp_misses++;                       // Refill fills the line
         exp_valid[idx] = 1'b1;
         exp_tag[idx]   = tg;
      end
   endtask

   task automatic wr(input logic [16:0] a, input logic [31:0] d, input logic [3:0] s);
      logic [3:0]                  idx;
      logic [cache_pkg::tag_w-1:0] tg;
      logic [11:0]                 w;
      logic [31:0]                 data;
      int                          nwr_exp;
      int                          wr0;
      int                          rd0;
      int                          lat;
      idx     = a[5:2];
      tg      = a[15:6];
      w       = a[13:2];
      nwr_exp = a[16] ? 0 : 1;               // Always written through
      wr0     = bus_writes;
      rd0     = bus_reads;
      front_access(a, d, s, data, lat);
      if (a[16])
      begin
         if (data !== '0)
            report_value("rdata", 32'd0, data);
         if (a[3:2] == cache_pkg::ctrl_clear)
         begin
            exp_hits   = 0;
            exp_misses = 0;
         end
         if (a[3:2] == cache_pkg::ctrl_invalidate)
            exp_valid = '0;
      end
      else
      begin
         if (exp_valid[idx] && exp_tag[idx] == tg)
            exp_hits++;
         else
            exp_misses++;                    // No allocate
         exp_mem[w] = merge_bytes(exp_mem[w], d, s);
         if (mem[w] !== exp_mem[w])
            report_value("memory word", exp_mem[w], mem[w]);
      end
      if (bus_writes - wr0 != nwr_exp)
         report_value("Wishbone writes", nwr_exp, bus_writes - wr0);
      if (bus_reads != rd0)
         report_value("Wishbone reads", 32'd0, bus_reads - rd0);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////////////////////////
   task automatic reset_idle();
      int err0;
      err0 = errors;
      for (int i = 0; i < 10; i++)
      begin
         @(negedge clk);
         if (ready !== 1'b0)
            report_value("ready", 32'd0, 32'(ready));
         if (wb_cyc !== 1'b0)
            report_value("wb_cyc", 32'd0, 32'(wb_cyc));
      end
      finish_test("reset_idle", err0);
   endtask

   task automatic miss_then_hit();
      logic [31:0] data;
      int          nrd;
      int          lat;
      int          err0;
      err0 = errors;
      rd(17'h00040, data, nrd, lat);
      if (nrd != 1)
         report_value("Wishbone reads", 32'd1, nrd);
      rd(17'h00040, data, nrd, lat);         // Same line, now cached
      if (nrd != 0)
         report_value("Wishbone reads", 32'd0, nrd);
      if (lat != 2)
         report_value("ready latency", 32'd2, lat);
      finish_test("miss_then_hit", err0);
   endtask

   task automatic strobed_write();
      logic [31:0] data;
      int          nrd;
      int          lat;
      int          err0;
      err0 = errors;
      wr(17'h00040, 32'h11223344, 4'b0101);  // Hit, bytes 0 and 2
      rd(17'h00040, data, nrd, lat);
      if (nrd != 0)
         report_value("Wishbone reads", 32'd0, nrd);
      wr(17'h00084, 32'hcafe0001, 4'b1111);  // Miss, index 1
      rd(17'h00084, data, nrd, lat);
      if (nrd != 1)
         report_value("Wishbone reads", 32'd1, nrd);
      finish_test("strobed_write", err0);
   endtask

   task automatic conflict_evict();
      logic [31:0] data;
      int          nrd;
      int          lat;
      int          err0;
      err0 = errors;
      for (int i = 0; i < 4; i++)
      begin
         rd(17'h00108, data, nrd, lat);      // Index 2, tag 4
         if (nrd != 1)
            report_value("Wishbone reads", 32'd1, nrd);
         rd(17'h00508, data, nrd, lat);      // Index 2, tag 20
         if (nrd != 1)
            report_value("Wishbone reads", 32'd1, nrd);
      end
      finish_test("conflict_evict", err0);
   endtask

   task automatic control_space();
      logic [31:0] data;
      int          nrd;
      int          lat;
      int          err0;
      err0 = errors;
      rd(17'h10000, data, nrd, lat);         // Hits
      if (lat != 2)
         report_value("ready latency", 32'd2, lat);
      rd(17'h10004, data, nrd, lat);         // Misses
      wr(17'h1000c, '0, 4'hf);               // Clear both
      rd(17'h10000, data, nrd, lat);
      if (data !== '0)
         report_value("hits", 32'd0, data);
      rd(17'h10004, data, nrd, lat);
      if (data !== '0)
         report_value("misses", 32'd0, data);
      rd(17'h00040, data, nrd, lat);         // Still cached
      wr(17'h10008, '0, 4'hf);               // Invalidate all lines
      rd(17'h00040, data, nrd, lat);
      if (nrd != 1)
         report_value("Wishbone reads", 32'd1, nrd);
      finish_test("control_space", err0);
   endtask

   task automatic random_mix();
      logic [31:0] data;
      logic [31:0] d;
      logic [3:0]  s;
      logic [5:0]  w;
      int          nrd;
      int          lat;
      int          err0;
      err0 = errors;
      for (int i = 0; i < 200; i++)
      begin
         w = 6'($random(seed));              // 64 words, 4 tags per line
         if ($random(seed) & 1)
         begin
            d = $random(seed);
            s = 4'($random(seed));
            if (s == 4'h0)
               s = 4'hf;
            wr({9'd0, w, 2'b00}, d, s);
         end
         else
            rd({9'd0, w, 2'b00}, data, nrd, lat);
      end
      rd(17'h10000, data, nrd, lat);         // Final counters
      rd(17'h10004, data, nrd, lat);
      finish_test("random_mix", err0);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////
   initial
   begin
      reset        = 1'b1;
      addr         = '0;
      wdata        = '0;
      wstrb        = '0;
      valid        = 1'b0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      model_init();
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      reset_idle();
      miss_then_hit();
      strobed_write();
      conflict_evict();
      control_space();
      random_mix();
      $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
               tests_run, tests_failed, errors, i_cache_top.i_cache_assert.fail_count);
      if (errors == 0 && tests_failed == 0 && i_cache_top.i_cache_assert.fail_count == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

// ==== all.f ====
design/cache_pkg.sv
design/cache_front_end.sv
design/cache_fsm.sv
design/cache_store.sv
design/cache_ctrl.sv
design/cache_top.sv
sim/cache_assert.sv
sim/cache_tb.sv

// ==== Makefile ====
# Verilator build and run of the cache testbench

VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
PASS_TEXT ?= TB PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the pass line shows up in the simulation output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
